//--- verilog/decode_pkg.sv
package decode_pkg;

  // ####################
  // Widths
  // ####################

  typedef logic [31:0] word_t;      // Instruction word, pc, npc, immediate, target
  typedef logic [4:0]  reg_addr_t;
  typedef logic [2:0]  unit_t;      // Execution unit class

  localparam int    lanes    = 2;
  localparam word_t empty_pc = '1;

  // ####################
  // Unit classes
  // ####################

  localparam unit_t unit_none   = 3'd0;
  localparam unit_t unit_alu    = 3'd1;
  localparam unit_t unit_branch = 3'd2;
  localparam unit_t unit_lsu    = 3'd3;
  localparam unit_t unit_csr    = 3'd4;
  localparam unit_t unit_muldiv = 3'd5;
  localparam unit_t unit_fpu    = 3'd6;
  localparam unit_t unit_system = 3'd7;  // Fence, ecall, ebreak, mret and wfi

  // ####################
  // Major opcodes
  // ####################

  localparam logic [6:0] lui      = 7'b0110111;
  localparam logic [6:0] auipc    = 7'b0010111;
  localparam logic [6:0] jal      = 7'b1101111;
  localparam logic [6:0] jalr     = 7'b1100111;
  localparam logic [6:0] branch   = 7'b1100011;
  localparam logic [6:0] load     = 7'b0000011;
  localparam logic [6:0] store    = 7'b0100011;
  localparam logic [6:0] op_imm   = 7'b0010011;
  localparam logic [6:0] op       = 7'b0110011;
  localparam logic [6:0] misc_mem = 7'b0001111;
  localparam logic [6:0] system   = 7'b1110011;
  localparam logic [6:0] load_fp  = 7'b0000111;
  localparam logic [6:0] store_fp = 7'b0100111;
  localparam logic [6:0] madd     = 7'b1000011;
  localparam logic [6:0] op_fp    = 7'b1010011;

  // Function codes in bits 31 to 25
  localparam logic [6:0] funct7_base = 7'b0000000;
  localparam logic [6:0] funct7_alt  = 7'b0100000;  // SUB and SRA forms
  localparam logic [6:0] funct7_mext = 7'b0000001;
  localparam logic [6:0] funct7_fadd = 7'b0000000;
  localparam logic [6:0] funct7_fsub = 7'b0000100;
  localparam logic [6:0] funct7_fmul = 7'b0001000;

  // Privileged instructions are matched on the whole word
  localparam word_t instr_ecall  = 32'h00000073;
  localparam word_t instr_ebreak = 32'h00100073;
  localparam word_t instr_mret   = 32'h30200073;
  localparam word_t instr_wfi    = 32'h10500073;

endpackage

//--- verilog/slot_if.sv
`timescale 1ns/100ps

interface fetch_slot_if import decode_pkg::*; ();
  word_t pc;
  word_t instr;
  logic  ready;
  logic  pred_taken;
  word_t pred_taddr;

  modport source (output pc, instr, ready, pred_taken, pred_taddr);
  modport sink   (input pc, instr, ready, pred_taken, pred_taddr);
endinterface

interface decoded_slot_if import decode_pkg::*; ();
  logic      valid;
  logic      exception;
  word_t     pc;
  word_t     npc;
  reg_addr_t rd;
  reg_addr_t rs1;
  reg_addr_t rs2;
  reg_addr_t rs3;
  word_t     imm;
  unit_t     unit;
  logic      wren;
  logic      rden1;
  logic      rden2;
  logic      fwren;
  logic      frden1;
  logic      frden2;
  logic      frden3;
  logic      pred_taken;
  word_t     pred_taddr;

  modport source (
    output valid, exception, pc, npc, rd, rs1, rs2, rs3, imm, unit,
           wren, rden1, rden2, fwren, frden1, frden2, frden3, pred_taken, pred_taddr
  );
  modport sink (
    input valid, exception, pc, npc, rd, rs1, rs2, rs3, imm, unit,
          wren, rden1, rden2, fwren, frden1, frden2, frden3, pred_taken, pred_taddr
  );
endinterface

//--- verilog/fetch_slotter.sv
`timescale 1ns/100ps

module fetch_slotter import decode_pkg::*; (
  input  logic              clock,
  input  logic              reset,
  input  logic              halt,
  input  logic [lanes-1:0]  ready,
  input  word_t [lanes-1:0] pc,
  input  word_t [lanes-1:0] instr,
  input  logic [lanes-1:0]  pred_taken,
  input  word_t [lanes-1:0] pred_taddr,
  fetch_slot_if.source      slot [lanes]
);

  logic [lanes-1:0]  hold_ready;
  word_t [lanes-1:0] hold_pc;
  word_t [lanes-1:0] hold_instr;
  logic [lanes-1:0]  hold_pred_taken;
  word_t [lanes-1:0] hold_pred_taddr;

  logic [lanes-1:0]  sel_ready;
  word_t [lanes-1:0] sel_pc;
  word_t [lanes-1:0] sel_instr;
  logic [lanes-1:0]  sel_pred_taken;
  word_t [lanes-1:0] sel_pred_taddr;

  // A halted stage sees the last packet taken while halt was low
  always_ff @(posedge clock) begin
    if (!reset) begin
      hold_ready <= '0;  // Empty slots until the first packet
    end else if (!halt) begin
      hold_ready <= ready;
    end
  end

  always_ff @(posedge clock) begin
    if (!halt) begin
      hold_pc         <= pc;
      hold_instr      <= instr;
      hold_pred_taken <= pred_taken;
      hold_pred_taddr <= pred_taddr;
    end
  end

  assign sel_ready      = halt ? hold_ready : ready;
  assign sel_pc         = halt ? hold_pc : pc;
  assign sel_instr      = halt ? hold_instr : instr;
  assign sel_pred_taken = halt ? hold_pred_taken : pred_taken;
  assign sel_pred_taddr = halt ? hold_pred_taddr : pred_taddr;

  for (genvar i = 0; i < lanes; i++) begin : g_slot
    assign slot[i].ready      = sel_ready[i];
    assign slot[i].pc         = sel_ready[i] ? sel_pc[i] : empty_pc;
    assign slot[i].instr      = sel_ready[i] ? sel_instr[i] : '0;
    assign slot[i].pred_taken = sel_ready[i] & sel_pred_taken[i];
    assign slot[i].pred_taddr = sel_ready[i] ? sel_pred_taddr[i] : '0;
  end

endmodule

//--- verilog/int_decoder.sv
`timescale 1ns/100ps

module int_decoder import decode_pkg::*; (
  input  word_t instr,
  output logic  valid,
  output logic  wren,
  output logic  rden1,
  output logic  rden2,
  output word_t imm,
  output unit_t unit
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_b;
  word_t      imm_u;
  word_t      imm_j;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  always_comb begin
    valid = 1'b0;
    wren  = 1'b0;
    rden1 = 1'b0;
    rden2 = 1'b0;
    imm   = '0;
    unit  = unit_none;
    case (opcode)
      lui, auipc: begin
        valid = 1'b1;
        wren  = 1'b1;
        imm   = imm_u;
        unit  = unit_alu;
      end
      jal: begin
        valid = 1'b1;
        wren  = 1'b1;
        imm   = imm_j;
        unit  = unit_branch;
      end
      jalr: begin
        valid = funct3 == 3'b000;
        wren  = 1'b1;
        rden1 = 1'b1;
        imm   = imm_i;
        unit  = unit_branch;
      end
      branch: begin
        valid = funct3[2:1] != 2'b01;  // Codes 2 and 3 are reserved
        rden1 = 1'b1;
        rden2 = 1'b1;
        imm   = imm_b;
        unit  = unit_branch;
      end
      load: begin
        valid = funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101};
        wren  = 1'b1;
        rden1 = 1'b1;
        imm   = imm_i;
        unit  = unit_lsu;
      end
      store: begin
        valid = funct3 inside {3'b000, 3'b001, 3'b010};
        rden1 = 1'b1;
        rden2 = 1'b1;
        imm   = imm_s;
        unit  = unit_lsu;
      end
      op_imm: begin
        // Shifts constrain the upper bits of the immediate
        case (funct3)
          3'b001:  valid = funct7 == funct7_base;
          3'b101:  valid = funct7 == funct7_base || funct7 == funct7_alt;
          default: valid = 1'b1;
        endcase
        wren  = 1'b1;
        rden1 = 1'b1;
        imm   = imm_i;
        unit  = unit_alu;
      end
      op: begin
        valid = funct7 == funct7_base || funct7 == funct7_mext ||
                (funct7 == funct7_alt && funct3 inside {3'b000, 3'b101});
        wren  = 1'b1;
        rden1 = 1'b1;
        rden2 = 1'b1;
        unit  = (funct7 == funct7_mext) ? unit_muldiv : unit_alu;
      end
      misc_mem: begin
        valid = funct3 == 3'b000;
        unit  = unit_system;
      end
      system: begin
        if (funct3 == 3'b000) begin
          valid = instr inside {instr_ecall, instr_ebreak, instr_mret, instr_wfi};
          unit  = unit_system;
        end else begin
          valid = funct3 != 3'b100;
          wren  = 1'b1;
          rden1 = !funct3[2];  // Immediate forms carry a 5-bit value in rs1
          imm   = funct3[2] ? {27'b0, instr[19:15]} : {20'b0, instr[31:20]};
          unit  = unit_csr;
        end
      end
      default: ;
    endcase
    if (!valid) begin
      wren  = 1'b0;
      rden1 = 1'b0;
      rden2 = 1'b0;
      imm   = '0;
      unit  = unit_none;
    end
  end

endmodule

//--- verilog/fp_decoder.sv
`timescale 1ns/100ps

module fp_decoder import decode_pkg::*; (
  input  word_t instr,
  output logic  valid,
  output logic  wren,
  output logic  rden1,
  output logic  fwren,
  output logic  frden1,
  output logic  frden2,
  output logic  frden3,
  output word_t imm,
  output unit_t unit
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  always_comb begin
    valid  = 1'b0;
    wren   = 1'b0;  // No supported FP instruction writes an integer register
    rden1  = 1'b0;
    fwren  = 1'b0;
    frden1 = 1'b0;
    frden2 = 1'b0;
    frden3 = 1'b0;
    imm    = '0;
    unit   = unit_none;
    case (opcode)
      load_fp: begin
        if (funct3 == 3'b010) begin  // FLW
          valid = 1'b1;
          rden1 = 1'b1;
          fwren = 1'b1;
          imm   = {{20{instr[31]}}, instr[31:20]};
          unit  = unit_lsu;
        end
      end
      store_fp: begin
        if (funct3 == 3'b010) begin  // FSW
          valid  = 1'b1;
          rden1  = 1'b1;
          frden2 = 1'b1;
          imm    = {{20{instr[31]}}, instr[31:25], instr[11:7]};
          unit   = unit_lsu;
        end
      end
      madd: begin
        if (instr[26:25] == 2'b00) begin  // Single precision only
          valid  = 1'b1;
          fwren  = 1'b1;
          frden1 = 1'b1;
          frden2 = 1'b1;
          frden3 = 1'b1;
          unit   = unit_fpu;
        end
      end
      op_fp: begin
        if (funct7 inside {funct7_fadd, funct7_fsub, funct7_fmul}) begin
          valid  = 1'b1;
          fwren  = 1'b1;
          frden1 = 1'b1;
          frden2 = 1'b1;
          unit   = unit_fpu;
        end
      end
      default: ;
    endcase
  end

endmodule

//--- verilog/decode_lane.sv
`timescale 1ns/100ps

module decode_lane import decode_pkg::*; (
  fetch_slot_if.sink     fetch,
  decoded_slot_if.source decoded
);

  logic  int_valid;
  logic  int_wren;
  logic  int_rden1;
  logic  int_rden2;
  word_t int_imm;
  unit_t int_unit;

  logic  fp_valid;
  logic  fp_wren;
  logic  fp_rden1;
  logic  fp_fwren;
  logic  fp_frden1;
  logic  fp_frden2;
  logic  fp_frden3;
  word_t fp_imm;
  unit_t fp_unit;

  int_decoder int_dec (
    .instr (fetch.instr),
    .valid (int_valid),
    .wren  (int_wren),
    .rden1 (int_rden1),
    .rden2 (int_rden2),
    .imm   (int_imm),
    .unit  (int_unit)
  );

  fp_decoder fp_dec (
    .instr  (fetch.instr),
    .valid  (fp_valid),
    .wren   (fp_wren),
    .rden1  (fp_rden1),
    .fwren  (fp_fwren),
    .frden1 (fp_frden1),
    .frden2 (fp_frden2),
    .frden3 (fp_frden3),
    .imm    (fp_imm),
    .unit   (fp_unit)
  );

  // Register fields sit at fixed positions in every format
  assign decoded.pc         = fetch.pc;
  assign decoded.npc        = fetch.pc + 32'd4;
  assign decoded.rd         = fetch.instr[11:7];
  assign decoded.rs1        = fetch.instr[19:15];
  assign decoded.rs2        = fetch.instr[24:20];
  assign decoded.rs3        = fetch.instr[31:27];
  assign decoded.pred_taken = fetch.pred_taken;
  assign decoded.pred_taddr = fetch.pred_taddr;

  always_comb begin
    decoded.valid     = int_valid | fp_valid;
    decoded.exception = 1'b0;
    decoded.imm       = fp_valid ? fp_imm : int_imm;
    decoded.unit      = fp_valid ? fp_unit : int_unit;
    decoded.wren      = fp_valid ? fp_wren : int_wren;
    decoded.rden1     = fp_valid ? fp_rden1 : int_rden1;
    decoded.rden2     = !fp_valid & int_rden2;
    decoded.fwren     = fp_valid & fp_fwren;
    decoded.frden1    = fp_valid & fp_frden1;
    decoded.frden2    = fp_valid & fp_frden2;
    decoded.frden3    = fp_valid & fp_frden3;
    // Illegal instruction goes down the pipe as an exception slot
    if (fetch.ready && !decoded.valid) begin
      decoded.valid     = 1'b1;
      decoded.exception = 1'b1;
      decoded.unit      = unit_none;
    end
  end

endmodule

//--- verilog/decode_register.sv
`timescale 1ns/100ps

module decode_register import decode_pkg::*; (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  fence_retire,
  input  logic                  trap,
  input  logic                  mret,
  input  logic                  pred_miss,
  decoded_slot_if.sink          decoded [lanes],
  output logic [lanes-1:0]      valid,
  output logic [lanes-1:0]      exception,
  output word_t [lanes-1:0]     pc,
  output word_t [lanes-1:0]     npc,
  output reg_addr_t [lanes-1:0] rd,
  output reg_addr_t [lanes-1:0] rs1,
  output reg_addr_t [lanes-1:0] rs2,
  output reg_addr_t [lanes-1:0] rs3,
  output word_t [lanes-1:0]     imm,
  output unit_t [lanes-1:0]     unit,
  output logic [lanes-1:0]      wren,
  output logic [lanes-1:0]      rden1,
  output logic [lanes-1:0]      rden2,
  output logic [lanes-1:0]      fwren,
  output logic [lanes-1:0]      frden1,
  output logic [lanes-1:0]      frden2,
  output logic [lanes-1:0]      frden3,
  output logic [lanes-1:0]      pred_taken,
  output word_t [lanes-1:0]     pred_taddr
);

  logic clear;

  // Any redirect from later stages flushes both slots
  assign clear = fence_retire | trap | mret | pred_miss;

  for (genvar i = 0; i < lanes; i++) begin : g_lane
    always_ff @(posedge clock) begin
      if (!reset || clear) begin
        valid[i]      <= 1'b0;
        exception[i]  <= 1'b0;
        pc[i]         <= empty_pc;
        npc[i]        <= empty_pc;
        rd[i]         <= '0;
        rs1[i]        <= '0;
        rs2[i]        <= '0;
        rs3[i]        <= '0;
        imm[i]        <= '0;
        unit[i]       <= unit_none;
        wren[i]       <= 1'b0;
        rden1[i]      <= 1'b0;
        rden2[i]      <= 1'b0;
        fwren[i]      <= 1'b0;
        frden1[i]     <= 1'b0;
        frden2[i]     <= 1'b0;
        frden3[i]     <= 1'b0;
        pred_taken[i] <= 1'b0;
        pred_taddr[i] <= '0;
      end else begin
        valid[i]      <= decoded[i].valid;
        exception[i]  <= decoded[i].exception;
        pc[i]         <= decoded[i].pc;
        npc[i]        <= decoded[i].npc;
        rd[i]         <= decoded[i].rd;
        rs1[i]        <= decoded[i].rs1;
        rs2[i]        <= decoded[i].rs2;
        rs3[i]        <= decoded[i].rs3;
        imm[i]        <= decoded[i].imm;
        unit[i]       <= decoded[i].unit;
        wren[i]       <= decoded[i].wren;
        rden1[i]      <= decoded[i].rden1;
        rden2[i]      <= decoded[i].rden2;
        fwren[i]      <= decoded[i].fwren;
        frden1[i]     <= decoded[i].frden1;
        frden2[i]     <= decoded[i].frden2;
        frden3[i]     <= decoded[i].frden3;
        pred_taken[i] <= decoded[i].pred_taken;
        pred_taddr[i] <= decoded[i].pred_taddr;
      end
    end
  end

endmodule

//--- verilog/decode_unit.sv
`timescale 1ns/100ps

module decode_unit import decode_pkg::*; (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  halt,
  input  logic                  fence_retire,
  input  logic                  trap,
  input  logic                  mret,
  input  logic                  pred_miss,
  input  logic [lanes-1:0]      fetch_ready,
  input  word_t [lanes-1:0]     fetch_pc,
  input  word_t [lanes-1:0]     fetch_instr,
  input  logic [lanes-1:0]      fetch_pred_taken,
  input  word_t [lanes-1:0]     fetch_pred_taddr,
  output logic [lanes-1:0]      valid,
  output logic [lanes-1:0]      exception,
  output word_t [lanes-1:0]     pc,
  output word_t [lanes-1:0]     npc,
  output reg_addr_t [lanes-1:0] rd,
  output reg_addr_t [lanes-1:0] rs1,
  output reg_addr_t [lanes-1:0] rs2,
  output reg_addr_t [lanes-1:0] rs3,
  output word_t [lanes-1:0]     imm,
  output unit_t [lanes-1:0]     unit,
  output logic [lanes-1:0]      wren,
  output logic [lanes-1:0]      rden1,
  output logic [lanes-1:0]      rden2,
  output logic [lanes-1:0]      fwren,
  output logic [lanes-1:0]      frden1,
  output logic [lanes-1:0]      frden2,
  output logic [lanes-1:0]      frden3,
  output logic [lanes-1:0]      pred_taken,
  output word_t [lanes-1:0]     pred_taddr
);

  fetch_slot_if   fetch_slot [lanes] ();
  decoded_slot_if decoded_slot [lanes] ();

  fetch_slotter slotter (
    .clock      (clock),
    .reset      (reset),
    .halt       (halt),
    .ready      (fetch_ready),
    .pc         (fetch_pc),
    .instr      (fetch_instr),
    .pred_taken (fetch_pred_taken),
    .pred_taddr (fetch_pred_taddr),
    .slot       (fetch_slot)
  );

  for (genvar i = 0; i < lanes; i++) begin : g_lane
    decode_lane lane (
      .fetch   (fetch_slot[i]),
      .decoded (decoded_slot[i])
    );
  end

  decode_register register (
    .clock        (clock),
    .reset        (reset),
    .fence_retire (fence_retire),
    .trap         (trap),
    .mret         (mret),
    .pred_miss    (pred_miss),
    .decoded      (decoded_slot),
    .valid        (valid),
    .exception    (exception),
    .pc           (pc),
    .npc          (npc),
    .rd           (rd),
    .rs1          (rs1),
    .rs2          (rs2),
    .rs3          (rs3),
    .imm          (imm),
    .unit         (unit),
    .wren         (wren),
    .rden1        (rden1),
    .rden2        (rden2),
    .fwren        (fwren),
    .frden1       (frden1),
    .frden2       (frden2),
    .frden3       (frden3),
    .pred_taken   (pred_taken),
    .pred_taddr   (pred_taddr)
  );

endmodule

//--- dv/decode_checker.sv
`timescale 1ns/100ps

module decode_checker import decode_pkg::*; (
  input  logic                  clock,
  input  logic                  check,
  input  logic                  exp_squash,
  input  word_t [lanes-1:0]     exp_pc,
  input  word_t [lanes-1:0]     exp_imm,
  input  logic [lanes-1:0][19:0] exp_regs,
  input  logic [lanes-1:0][12:0] exp_flags,
  input  word_t [lanes-1:0]     exp_taddr,
  input  logic [lanes-1:0]      valid,
  input  logic [lanes-1:0]      exception,
  input  word_t [lanes-1:0]     pc,
  input  word_t [lanes-1:0]     npc,
  input  reg_addr_t [lanes-1:0] rd,
  input  reg_addr_t [lanes-1:0] rs1,
  input  reg_addr_t [lanes-1:0] rs2,
  input  reg_addr_t [lanes-1:0] rs3,
  input  word_t [lanes-1:0]     imm,
  input  unit_t [lanes-1:0]     unit,
  input  logic [lanes-1:0]      wren,
  input  logic [lanes-1:0]      rden1,
  input  logic [lanes-1:0]      rden2,
  input  logic [lanes-1:0]      fwren,
  input  logic [lanes-1:0]      frden1,
  input  logic [lanes-1:0]      frden2,
  input  logic [lanes-1:0]      frden3,
  input  logic [lanes-1:0]      pred_taken,
  input  word_t [lanes-1:0]     pred_taddr,
  output int                    errors,
  output int                    checks
);

  initial begin
    errors = 0;
    checks = 0;
  end

  task automatic compare_field(input string name, input int lane,
                               input logic [31:0] expected, input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("Error: lane %0d %s expected %h actual %h", lane, name, expected, actual);
    end
  endtask

  task automatic compare_lane(input int i);
    word_t exp_npc;
    // A squashed slot carries empty_pc in npc as well as in pc
    exp_npc = exp_squash ? empty_pc : exp_pc[i] + 32'd4;
    compare_field("valid", i, 32'(exp_flags[i][12]), 32'(valid[i]));
    compare_field("exception", i, 32'(exp_flags[i][11]), 32'(exception[i]));
    compare_field("unit", i, 32'(exp_flags[i][10:8]), 32'(unit[i]));
    compare_field("wren", i, 32'(exp_flags[i][7]), 32'(wren[i]));
    compare_field("rden1", i, 32'(exp_flags[i][6]), 32'(rden1[i]));
    compare_field("rden2", i, 32'(exp_flags[i][5]), 32'(rden2[i]));
    compare_field("fwren", i, 32'(exp_flags[i][4]), 32'(fwren[i]));
    compare_field("frden1", i, 32'(exp_flags[i][3]), 32'(frden1[i]));
    compare_field("frden2", i, 32'(exp_flags[i][2]), 32'(frden2[i]));
    compare_field("frden3", i, 32'(exp_flags[i][1]), 32'(frden3[i]));
    compare_field("pred_taken", i, 32'(exp_flags[i][0]), 32'(pred_taken[i]));
    compare_field("pc", i, exp_pc[i], pc[i]);
    compare_field("npc", i, exp_npc, npc[i]);
    compare_field("rd", i, 32'(exp_regs[i][19:15]), 32'(rd[i]));
    compare_field("rs1", i, 32'(exp_regs[i][14:10]), 32'(rs1[i]));
    compare_field("rs2", i, 32'(exp_regs[i][9:5]), 32'(rs2[i]));
    compare_field("rs3", i, 32'(exp_regs[i][4:0]), 32'(rs3[i]));
    compare_field("imm", i, exp_imm[i], imm[i]);
    compare_field("pred_taddr", i, exp_taddr[i], pred_taddr[i]);
  endtask

  // Registered outputs settle right after the rising edge
  always @(posedge clock) begin
    #1;
    if (check) begin
      for (int i = 0; i < lanes; i++) begin
        compare_lane(i);
      end
    end
  end

endmodule

//--- dv/tb_decode_unit.sv
`timescale 1ns/100ps

module tb_decode_unit import decode_pkg::*; ();

  localparam int max_cycles   = 64;
  localparam int reset_cycles = 10;

  logic clock;
  logic reset;
  logic halt;
  logic fence_retire;
  logic trap;
  logic mret;
  logic pred_miss;
  logic check;

  logic [lanes-1:0]  fetch_ready;
  word_t [lanes-1:0] fetch_pc;
  word_t [lanes-1:0] fetch_instr;
  logic [lanes-1:0]  fetch_pred_taken;
  word_t [lanes-1:0] fetch_pred_taddr;

  logic [lanes-1:0]      valid;
  logic [lanes-1:0]      exception;
  word_t [lanes-1:0]     pc;
  word_t [lanes-1:0]     npc;
  reg_addr_t [lanes-1:0] rd;
  reg_addr_t [lanes-1:0] rs1;
  reg_addr_t [lanes-1:0] rs2;
  reg_addr_t [lanes-1:0] rs3;
  word_t [lanes-1:0]     imm;
  unit_t [lanes-1:0]     unit;
  logic [lanes-1:0]      wren;
  logic [lanes-1:0]      rden1;
  logic [lanes-1:0]      rden2;
  logic [lanes-1:0]      fwren;
  logic [lanes-1:0]      frden1;
  logic [lanes-1:0]      frden2;
  logic [lanes-1:0]      frden3;
  logic [lanes-1:0]      pred_taken;
  word_t [lanes-1:0]     pred_taddr;

  logic                   exp_squash;
  word_t [lanes-1:0]      exp_pc;
  word_t [lanes-1:0]      exp_imm;
  logic [lanes-1:0][19:0] exp_regs;
  logic [lanes-1:0][12:0] exp_flags;
  word_t [lanes-1:0]      exp_taddr;

  int errors;
  int checks;
  int cycles;
  int cycle_limit;
  int num_records;
  string load_error;

  // ####################
  // Trace records
  // ####################

  logic [5:0]  rec_ctrl  [max_cycles];
  logic [1:0]  rec_rp    [max_cycles][lanes];
  word_t       rec_pc    [max_cycles][lanes];
  word_t       rec_instr [max_cycles][lanes];
  word_t       rec_taddr [max_cycles][lanes];
  word_t       rec_epc   [max_cycles][lanes];
  word_t       rec_eimm  [max_cycles][lanes];
  logic [19:0] rec_eregs [max_cycles][lanes];
  logic [12:0] rec_eflag [max_cycles][lanes];
  word_t       rec_etadr [max_cycles][lanes];

  decode_unit dut (.*);

  decode_checker scoreboard (
    .clock (clock), .check (check), .exp_squash (exp_squash), .exp_pc (exp_pc),
    .exp_imm (exp_imm), .exp_regs (exp_regs), .exp_flags (exp_flags),
    .exp_taddr (exp_taddr),
    .valid (valid), .exception (exception), .pc (pc), .npc (npc), .rd (rd),
    .rs1 (rs1), .rs2 (rs2), .rs3 (rs3), .imm (imm), .unit (unit), .wren (wren),
    .rden1 (rden1), .rden2 (rden2), .fwren (fwren), .frden1 (frden1),
    .frden2 (frden2), .frden3 (frden3), .pred_taken (pred_taken),
    .pred_taddr (pred_taddr), .errors (errors), .checks (checks)
  );

  initial clock = 1'b0;
  always #2 clock = ~clock;

  task automatic load_trace();
    int fd;
    int status;
    int lane;
    string line;
    logic [31:0] f [11];
    lane = 0;
    num_records = 0;
    fd = $fopen("dv/decode_trace.txt", "r");
    if (fd == 0) begin
      load_error = "Could not open the trace file dv/decode_trace.txt";
      return;
    end
    while (!$feof(fd) && load_error == "") begin
      line = "";
      status = $fgets(line, fd);
      if (status == 0 || line.len() < 2 || line.substr(0, 0) == "#") continue;
      status = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h", f[0], f[1], f[2],
                       f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10]);
      if (status != 11 || f[0] != 32'(lane) || num_records >= max_cycles) begin
        load_error = $sformatf("Trace line out of order or malformed: %s", line);
      end else begin
        rec_ctrl[num_records]        = f[1][5:0];  // Taken from every lane line
        rec_rp[num_records][lane]    = f[2][1:0];
        rec_pc[num_records][lane]    = f[3];
        rec_instr[num_records][lane] = f[4];
        rec_taddr[num_records][lane] = f[5];
        rec_epc[num_records][lane]   = f[6];
        rec_eimm[num_records][lane]  = f[7];
        rec_eregs[num_records][lane] = f[8][19:0];
        rec_eflag[num_records][lane] = f[9][12:0];
        rec_etadr[num_records][lane] = f[10];
        lane = (lane + 1) % lanes;
        if (lane == 0) num_records++;
      end
    end
    $fclose(fd);
  endtask

  task automatic drive_record(input int k);
    reset        = !rec_ctrl[k][5];
    halt         = rec_ctrl[k][4];
    fence_retire = rec_ctrl[k][3];
    trap         = rec_ctrl[k][2];
    mret         = rec_ctrl[k][1];
    pred_miss    = rec_ctrl[k][0];
    // Reset and every clear source leave the squashed pattern behind
    exp_squash   = rec_ctrl[k][5] | (|rec_ctrl[k][3:0]);
    for (int i = 0; i < lanes; i++) begin
      fetch_ready[i]      = rec_rp[k][i][1];
      fetch_pred_taken[i] = rec_rp[k][i][0];
      fetch_pc[i]         = rec_pc[k][i];
      fetch_instr[i]      = rec_instr[k][i];
      fetch_pred_taddr[i] = rec_taddr[k][i];
      exp_pc[i]           = rec_epc[k][i];
      exp_imm[i]          = rec_eimm[k][i];
      exp_regs[i]         = rec_eregs[k][i];
      exp_flags[i]        = rec_eflag[k][i];
      exp_taddr[i]        = rec_etadr[k][i];
    end
    check = 1'b1;
  endtask

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("TB FAILED");
    $finish;
  endtask

  always @(posedge clock) begin
    cycles++;
    if (cycles > cycle_limit) abort_run("Timeout, the trace did not finish in time");
  end

  initial begin
    reset = 1'b0;
    {halt, fence_retire, trap, mret, pred_miss, check, exp_squash} = '0;
    {fetch_ready, fetch_pc, fetch_instr, fetch_pred_taken, fetch_pred_taddr} = '0;
    {exp_pc, exp_imm, exp_regs, exp_flags, exp_taddr} = '0;
    cycles = 0;
    cycle_limit = max_cycles + reset_cycles + 20;
    load_error = "";
    load_trace();
    if (load_error != "") begin
      abort_run(load_error);
    end else begin
      cycle_limit = num_records + reset_cycles + 20;
      repeat (reset_cycles) @(negedge clock);
      for (int k = 0; k < num_records; k++) begin
        drive_record(k);
        @(negedge clock);
      end
      check = 1'b0;
      $display("%0d errors in %0d checks over %0d cycles", errors, checks, num_records);
      if (errors == 0) begin
        $display("TB PASSED");
      end else begin
        $display("TB FAILED");
      end
      $finish;
    end
  end

endmodule

//--- dv/decode_trace.txt
# lane ctrl rp pc instr taddr | expected pc imm regs flags taddr, all hex; ctrl = reset,halt,fence,trap,mret,miss
# rp = ready,pred_taken; regs = rd,rs1,rs2,rs3; flags = valid,exc,unit[3],wren,rden1,rden2,fwren,frden1..3,pt
# Reset still held, decoded values must not appear
0 20 2 00001000 ffb10093 00000000 ffffffff 00000000 00000 0000 00000000
1 20 3 00001004 fe418ce3 00000ffc ffffffff 00000000 00000 0000 00000000
# ADDI and BEQ, then LW and MUL
0 00 2 00001000 ffb10093 00000000 00001000 fffffffb 08b7f 11c0 00000000
1 00 3 00001004 fe418ce3 00000ffc 00001004 fffffff8 c8c9f 1261 00000ffc
0 00 2 00001008 01032283 00000000 00001008 00000010 29a00 13c0 00000000
1 00 2 0000100c 029403b3 00000000 0000100c 00000000 3a120 15e0 00000000
# FLW beside ADD, then FMADD.S and FADD.S
0 00 2 00001010 00812087 00000000 00001010 00000008 08900 1350 00000000
1 00 2 00001014 00c58533 00000000 00001014 00000000 52d80 11e0 00000000
0 00 2 00001018 18208243 00000000 00001018 00000000 20443 161e 00000000
1 00 3 0000101c 007302d3 00002000 0000101c 00000000 298e0 161d 00002000
# Unknown opcode and a slot that is not ready
0 00 2 00001020 0000007f 00000000 00001020 00000000 00000 1800 00000000
1 00 1 00001024 00100093 00001234 ffffffff 00000000 00000 0000 00000000
# Accepted packet, then three halted cycles with new inputs
0 00 2 00001030 ffb10093 00000000 00001030 fffffffb 08b7f 11c0 00000000
1 00 2 00001034 01032283 00000000 00001034 00000010 29a00 13c0 00000000
0 10 2 00002000 029403b3 00000000 00001030 fffffffb 08b7f 11c0 00000000
1 10 3 00002004 00812087 00003000 00001034 00000010 29a00 13c0 00000000
0 10 2 00002000 029403b3 00000000 00001030 fffffffb 08b7f 11c0 00000000
1 10 3 00002004 00812087 00003000 00001034 00000010 29a00 13c0 00000000
0 10 2 00002000 029403b3 00000000 00001030 fffffffb 08b7f 11c0 00000000
1 10 3 00002004 00812087 00003000 00001034 00000010 29a00 13c0 00000000
0 00 2 00002000 029403b3 00000000 00002000 00000000 3a120 15e0 00000000
1 00 3 00002004 00812087 00003000 00002004 00000008 08900 1351 00003000
# MRET during halt squashes, the held packet comes back after it
0 12 2 00001040 ffb10093 00000000 ffffffff 00000000 00000 0000 00000000
1 12 3 00001044 fe418ce3 0000103c ffffffff 00000000 00000 0000 00000000
0 10 2 00001040 ffb10093 00000000 00002000 00000000 3a120 15e0 00000000
1 10 3 00001044 fe418ce3 0000103c 00002004 00000008 08900 1351 00003000
# Fence retire, trap, mret and prediction miss one at a time
0 08 2 00001040 ffb10093 00000000 ffffffff 00000000 00000 0000 00000000
1 08 3 00001044 fe418ce3 0000103c ffffffff 00000000 00000 0000 00000000
0 04 2 00001040 ffb10093 00000000 ffffffff 00000000 00000 0000 00000000
1 04 3 00001044 fe418ce3 0000103c ffffffff 00000000 00000 0000 00000000
0 02 2 00001040 ffb10093 00000000 ffffffff 00000000 00000 0000 00000000
1 02 3 00001044 fe418ce3 0000103c ffffffff 00000000 00000 0000 00000000
0 01 2 00001040 ffb10093 00000000 ffffffff 00000000 00000 0000 00000000
1 01 3 00001044 fe418ce3 0000103c ffffffff 00000000 00000 0000 00000000
# Normal flow again, then both slots empty
0 00 2 00001040 ffb10093 00000000 00001040 fffffffb 08b7f 11c0 00000000
1 00 3 00001044 fe418ce3 0000103c 00001044 fffffff8 c8c9f 1261 0000103c
0 00 0 00001048 ffb10093 00000000 ffffffff 00000000 00000 0000 00000000
1 00 0 0000104c fe418ce3 00000000 ffffffff 00000000 00000 0000 00000000

//--- all.f
verilog/decode_pkg.sv
verilog/slot_if.sv
verilog/fetch_slotter.sv
verilog/int_decoder.sv
verilog/fp_decoder.sv
verilog/decode_lane.sv
verilog/decode_register.sv
verilog/decode_unit.sv
dv/decode_checker.sv
dv/tb_decode_unit.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the decode stage testbench with Verilator
set -u
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_decode_unit -f all.f \
  --Mdir obj_dir -o sim_decode > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "Build failed"
  exit 1
fi

./obj_dir/sim_decode > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "TB FAILED" sim.log; then
  exit 1
fi
exit 0
